/* Makefile */
# Verilator build and run for the SDRAM controller command side.

VERILATOR ?= verilator
TOP ?= hpdmc_tb
FILELIST ?= hpdmc.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* design/hpdmc_arbiter.sv */
// Two clients only; each must hold req, we and addr stable until its ack pulse.

module hpdmc_arbiter (
	input logic sys_clk,
	input logic sdram_rst,

	input logic req_0,
	input logic we_0,
	input hpdmc_cmd_pkg::mem_addr_t addr_0,
	output logic ack_0,

	input logic req_1,
	input logic we_1,
	input hpdmc_cmd_pkg::mem_addr_t addr_1,
	output logic ack_1,

	output logic sel_req,
	output logic sel_we,
	output hpdmc_cmd_pkg::mem_addr_t sel_addr,
	input logic ack
);

	logic busy; // A grant is held.
	logic gnt; // Granted client.
	logic prio; // Client preferred at the next grant.

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			busy <= 1'b0;
			gnt <= 1'b0;
			prio <= 1'b0;
		end else if (busy) begin
			if (ack) begin
				busy <= 1'b0;
				prio <= ~gnt; // Other client goes first next time.
			end
		end else if (req_0 | req_1) begin
			busy <= 1'b1;
			gnt <= prio ? req_1 : ~req_0; // Preferred client wins a tie.
		end
	end

	// Granted request to the sequencer.
	assign sel_req = busy & (gnt ? req_1 : req_0);
	assign sel_we = gnt ? we_1 : we_0;
	assign sel_addr = gnt ? addr_1 : addr_0;

	// Ack goes back only to the granted client.
	assign ack_0 = ack & busy & ~gnt;
	assign ack_1 = ack & busy & gnt;

endmodule

/* design/hpdmc_banktimer.sv */
// One timer per bank, so the strobes must be pre-gated with the bank select; burst length 8 is assumed.
`include "hpdmc_config.svh"

module hpdmc_banktimer (
	input logic sys_clk,
	input logic sdram_rst,

	input hpdmc_timing_pkg::cas_t tim_cas,
	input hpdmc_timing_pkg::twr_t tim_wr,

	input logic read,
	input logic write,
	output logic precharge_safe
);

	import hpdmc_timing_pkg::*;

	tcnt_t counter; // Cycles left before the bank may close.
	tcnt_t read_load;
	tcnt_t write_load;

	// A read burst is out of the array CL-1 cycles after the last column.
	assign read_load = tcnt_t'(`HPDMC_BURST_LEN - 1) + tcnt_t'(tim_cas);

	// Write recovery runs after the last word is written.
	assign write_load = tcnt_t'(`HPDMC_BURST_LEN + 1) + tcnt_t'(tim_wr);

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			counter <= '0;
			precharge_safe <= 1'b1; // Every bank idle after reset.
		end else begin
			if (read) begin
				counter <= read_load;
				precharge_safe <= 1'b0;
			end else if (write) begin
				counter <= write_load; // Longer than any read load.
				precharge_safe <= 1'b0;
			end else begin
				if (counter == tcnt_t'(1))
					precharge_safe <= 1'b1; // Bank free next cycle.
				if (!precharge_safe)
					counter <= counter - 1'b1;
			end
		end
	end

endmodule

/* design/hpdmc_cmd_pkg.sv */
// Client word address is {bank, row, column} with the bank in the top bits, and commands are abstract.
`include "hpdmc_config.svh"

package hpdmc_cmd_pkg;

	typedef logic [`HPDMC_BANK_W-1:0] bank_t; // Bank number.
	typedef logic [`HPDMC_NBANKS-1:0] bank_mask_t; // One bit per bank.
	typedef logic [`HPDMC_ROW_W-1:0] row_t; // Row address, also the A bus.
	typedef logic [`HPDMC_COL_W-1:0] col_t; // Column address.
	typedef logic [`HPDMC_BANK_W+`HPDMC_ROW_W+`HPDMC_COL_W-1:0] mem_addr_t; // 24-bit word.

	typedef enum logic [2:0] {
		cmd_nop = 3'd0, // Idle bus.
		cmd_activate = 3'd1, // Open a row.
		cmd_read = 3'd2, // Read burst.
		cmd_write = 3'd3, // Write burst.
		cmd_precharge = 3'd4, // Close one bank, or all with A10.
		cmd_refresh = 3'd5 // Auto-refresh.
	} sdram_cmd_t;

	function automatic bank_t addr_bank(mem_addr_t addr);
		return addr[`HPDMC_COL_W+`HPDMC_ROW_W +: `HPDMC_BANK_W]; // Top field.
	endfunction

	function automatic row_t addr_row(mem_addr_t addr);
		return addr[`HPDMC_COL_W +: `HPDMC_ROW_W]; // Middle field.
	endfunction

	function automatic col_t addr_col(mem_addr_t addr);
		return addr[`HPDMC_COL_W-1:0]; // Low field.
	endfunction

endpackage

/* design/hpdmc_config.svh */
// SDR SDRAM geometry and fixed command gaps, given in sys_clk cycles for one rank with burst length 8.
`ifndef HPDMC_CONFIG_SVH
`define HPDMC_CONFIG_SVH

// Geometry of the single rank.
`define HPDMC_NBANKS 4
`define HPDMC_BANK_W 2
`define HPDMC_ROW_W 13
`define HPDMC_COL_W 9

// Words per burst. The data-control counters assume 8.
`define HPDMC_BURST_LEN 8

// Cycles between two refresh requests.
`define HPDMC_REFRESH_CYCLES 390

// Precharge period in cycles.
`define HPDMC_TRP 2
// Activate to read or write in cycles.
`define HPDMC_TRCD 2
// Refresh to next command in cycles.
`define HPDMC_TRFC 8

`endif

/* design/hpdmc_ctl.sv */
// Command side only; DQ data, masks, power-up init and mode register setup live outside this block.

module hpdmc_ctl (
	input logic sys_clk,
	input logic sdram_rst,

	input hpdmc_timing_pkg::cas_t tim_cas,
	input hpdmc_timing_pkg::twr_t tim_wr,

	input logic req_0,
	input logic we_0,
	input hpdmc_cmd_pkg::mem_addr_t addr_0,
	output logic ack_0,

	input logic req_1,
	input logic we_1,
	input hpdmc_cmd_pkg::mem_addr_t addr_1,
	output logic ack_1,

	output hpdmc_cmd_pkg::sdram_cmd_t sdram_cmd,
	output hpdmc_cmd_pkg::bank_t sdram_ba,
	output hpdmc_cmd_pkg::row_t sdram_a,
	output logic dq_oe,
	output logic dq_oe_r
);

	import hpdmc_cmd_pkg::*;

	logic sel_req; // Granted request.
	logic sel_we;
	mem_addr_t sel_addr;
	logic ack; // Transfer done.
	logic read; // Read strobe.
	logic write; // Write strobe.
	bank_mask_t concerned_bank;
	logic read_safe;
	logic write_safe;
	bank_mask_t precharge_safe;

	hpdmc_arbiter i_arbiter (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.req_0(req_0),
		.we_0(we_0),
		.addr_0(addr_0),
		.ack_0(ack_0),
		.req_1(req_1),
		.we_1(we_1),
		.addr_1(addr_1),
		.ack_1(ack_1),
		.sel_req(sel_req),
		.sel_we(sel_we),
		.sel_addr(sel_addr),
		.ack(ack)
	);

	hpdmc_mgmt i_mgmt (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.sel_req(sel_req),
		.sel_we(sel_we),
		.sel_addr(sel_addr),
		.ack(ack),
		.read(read),
		.write(write),
		.concerned_bank(concerned_bank),
		.read_safe(read_safe),
		.write_safe(write_safe),
		.precharge_safe(precharge_safe),
		.sdram_cmd(sdram_cmd),
		.sdram_ba(sdram_ba),
		.sdram_a(sdram_a)
	);

	hpdmc_datactl i_datactl (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.read(read),
		.write(write),
		.concerned_bank(concerned_bank),
		.read_safe(read_safe),
		.write_safe(write_safe),
		.precharge_safe(precharge_safe),
		.ack(ack),
		.direction(dq_oe), // Drives the DQ tri-state enable.
		.direction_r(dq_oe_r),
		.tim_cas(tim_cas),
		.tim_wr(tim_wr)
	);

endmodule

/* design/hpdmc_datactl.sv */
// Strobes must coincide with the command on the pins; load values assume burst 8 and CL2 or CL3.
`include "hpdmc_config.svh"

module hpdmc_datactl (
	input logic sys_clk,
	input logic sdram_rst,

	input logic read,
	input logic write,
	input hpdmc_cmd_pkg::bank_mask_t concerned_bank,
	output logic read_safe,
	output logic write_safe,
	output hpdmc_cmd_pkg::bank_mask_t precharge_safe,

	output logic ack,
	output logic direction,
	output logic direction_r,

	input hpdmc_timing_pkg::cas_t tim_cas,
	input hpdmc_timing_pkg::twr_t tim_wr
);

	import hpdmc_timing_pkg::*;

	tcnt_t read_safe_counter; // Cycles until a read may be registered.
	tcnt_t write_safe_counter; // Cycles until a write may be registered.
	tcnt_t dir_counter; // Remaining DQ drive cycles.

	logic ack_rd2; // Extra stage used only at CL3.
	logic ack_rd1;
	logic ack_rd0;
	logic ack_rd; // Read ack one cycle early.
	logic ack_wr; // Write ack one cycle early.

	// Read after read waits 7, read after write 7 at CL2 and 6 at CL3.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			read_safe_counter <= '0;
			read_safe <= 1'b1;
		end else begin
			if (read) begin
				read_safe_counter <= tcnt_t'(7);
				read_safe <= 1'b0;
			end else if (write) begin
				read_safe_counter <= tcnt_t'(7) - tcnt_t'(tim_cas); // Shorter at CL3.
				read_safe <= 1'b0;
			end else begin
				if (read_safe_counter == tcnt_t'(1))
					read_safe <= 1'b1;
				if (!read_safe)
					read_safe_counter <= read_safe_counter - 1'b1;
			end
		end
	end

	// Write after read waits 9 at CL2 and 8 at CL3, write after write 7.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			write_safe_counter <= '0;
			write_safe <= 1'b1;
		end else begin
			if (read) begin
				write_safe_counter <= tcnt_t'(9) - tcnt_t'(tim_cas); // Bus turnaround.
				write_safe <= 1'b0;
			end else if (write) begin
				write_safe_counter <= tcnt_t'(7);
				write_safe <= 1'b0;
			end else begin
				if (write_safe_counter == tcnt_t'(1))
					write_safe <= 1'b1;
				if (!write_safe)
					write_safe_counter <= write_safe_counter - 1'b1;
			end
		end
	end

	// Ack lands CL+2 cycles after a read and 2 cycles after a write.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			ack_rd2 <= 1'b0;
			ack_rd1 <= 1'b0;
			ack_rd0 <= 1'b0;
			ack_rd <= 1'b0;
			ack_wr <= 1'b0;
			ack <= 1'b0;
		end else begin
			ack_rd2 <= read & tim_cas;
			ack_rd1 <= tim_cas ? ack_rd2 : read; // CL2 skips one stage.
			ack_rd0 <= ack_rd1;
			ack_rd <= ack_rd0;
			ack_wr <= write;
			ack <= ack_rd | ack_wr;
		end
	end

	// Registered enable keeps the DQ tri-state glitch-free over a 10-cycle window.
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			dir_counter <= '0;
			direction <= 1'b0;
		end else begin
			if (write) begin
				dir_counter <= tcnt_t'(9); // Retriggers an open window.
				direction <= 1'b1;
			end else if (dir_counter == '0) begin
				direction <= 1'b0;
			end else begin
				dir_counter <= dir_counter - 1'b1;
			end
		end
	end

	assign direction_r = write | (|dir_counter); // Early view, one cycle ahead.

	// One precharge guard per bank.
	for (genvar i = 0; i < `HPDMC_NBANKS; i++) begin : g_bank
		hpdmc_banktimer i_banktimer (
			.sys_clk(sys_clk),
			.sdram_rst(sdram_rst),
			.tim_cas(tim_cas),
			.tim_wr(tim_wr),
			.read(read & concerned_bank[i]),
			.write(write & concerned_bank[i]),
			.precharge_safe(precharge_safe[i])
		);
	end

endmodule

/* design/hpdmc_mgmt.sv */
// One request in flight, no auto-precharge, and every refresh is preceded by a precharge of all banks.
`include "hpdmc_config.svh"

module hpdmc_mgmt (
	input logic sys_clk,
	input logic sdram_rst,

	input logic sel_req,
	input logic sel_we,
	input hpdmc_cmd_pkg::mem_addr_t sel_addr,
	input logic ack,

	output logic read,
	output logic write,
	output hpdmc_cmd_pkg::bank_mask_t concerned_bank,
	input logic read_safe,
	input logic write_safe,
	input hpdmc_cmd_pkg::bank_mask_t precharge_safe,

	output hpdmc_cmd_pkg::sdram_cmd_t sdram_cmd,
	output hpdmc_cmd_pkg::bank_t sdram_ba,
	output hpdmc_cmd_pkg::row_t sdram_a
);

	import hpdmc_cmd_pkg::*;
	import hpdmc_timing_pkg::*;

	localparam row_t a_all_banks = row_t'(1) << 10; // A10 selects every bank.
	localparam refcnt_t ref_reload = refcnt_t'(`HPDMC_REFRESH_CYCLES - 1);

	mgmt_state_t state;
	tcnt_t wait_cnt; // tRP, tRCD or tRFC countdown.
	refcnt_t ref_cnt; // Refresh interval countdown.
	logic ref_pending; // Refresh owed.
	logic ref_run; // Precharge-all belongs to a refresh.
	logic issued; // Command sent, ack outstanding.
	row_t open_row [`HPDMC_NBANKS]; // Row held open per bank.
	bank_mask_t row_valid; // Bank has an open row.

	bank_t req_bank;
	row_t req_row;
	col_t req_col;
	logic row_hit;
	logic do_activate;
	logic cmd_safe;

	assign req_bank = addr_bank(sel_addr);
	assign req_row = addr_row(sel_addr);
	assign req_col = addr_col(sel_addr);
	assign row_hit = row_valid[req_bank] && (open_row[req_bank] == req_row);
	assign do_activate = (state == st_idle) && !ref_pending && sel_req && !row_valid[req_bank];
	assign cmd_safe = sel_we ? write_safe : read_safe;
	assign concerned_bank = bank_mask_t'(1) << sdram_ba; // Valid with each strobe.

	always_ff @(posedge sys_clk) begin
		if (do_activate)
			open_row[req_bank] <= req_row;
	end

	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			state <= st_idle;
			sdram_cmd <= cmd_nop;
			sdram_ba <= '0;
			sdram_a <= '0;
			read <= 1'b0;
			write <= 1'b0;
			wait_cnt <= '0;
			ref_cnt <= ref_reload;
			ref_pending <= 1'b0;
			ref_run <= 1'b0;
			issued <= 1'b0;
			row_valid <= '0;
		end else begin
			sdram_cmd <= cmd_nop; // Commands last one cycle.
			read <= 1'b0;
			write <= 1'b0;
			if (wait_cnt != '0)
				wait_cnt <= wait_cnt - 1'b1;
			case (state)
				st_idle: begin
					if (ref_pending) begin
						if (&precharge_safe) begin
							sdram_cmd <= cmd_precharge; // Close all before refresh.
							sdram_a <= a_all_banks;
							row_valid <= '0;
							ref_run <= 1'b1;
							wait_cnt <= tcnt_t'(`HPDMC_TRP - 1);
							state <= st_precharge_wait;
						end
					end else if (sel_req) begin
						if (row_hit) begin
							state <= st_issue; // Row already open.
						end else if (do_activate) begin
							sdram_cmd <= cmd_activate;
							sdram_ba <= req_bank;
							sdram_a <= req_row;
							row_valid[req_bank] <= 1'b1;
							wait_cnt <= tcnt_t'(`HPDMC_TRCD - 1);
							state <= st_activate_wait;
						end else if (precharge_safe[req_bank]) begin
							sdram_cmd <= cmd_precharge; // Row miss closes the bank.
							sdram_ba <= req_bank;
							sdram_a <= '0;
							row_valid[req_bank] <= 1'b0;
							wait_cnt <= tcnt_t'(`HPDMC_TRP - 1);
							state <= st_precharge_wait;
						end
					end
				end
				st_precharge_wait: begin
					if (wait_cnt == '0) begin
						if (ref_run) begin
							sdram_cmd <= cmd_refresh;
							ref_pending <= 1'b0;
							wait_cnt <= tcnt_t'(`HPDMC_TRFC - 1);
							state <= st_refresh_wait;
						end else begin
							state <= st_idle; // Activate follows from idle.
						end
					end
				end
				st_activate_wait: begin
					if (wait_cnt == '0)
						state <= st_issue;
				end
				st_issue: begin
					if (!issued) begin
						if (cmd_safe) begin
							sdram_cmd <= sel_we ? cmd_write : cmd_read;
							write <= sel_we;
							read <= !sel_we;
							sdram_ba <= req_bank;
							sdram_a <= row_t'(req_col); // A10 low, no auto-precharge.
							issued <= 1'b1;
						end
					end else if (ack) begin
						issued <= 1'b0;
						state <= st_idle;
					end
				end
				st_refresh_wait: begin
					if (wait_cnt == '0) begin
						ref_run <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
			if (ref_cnt == '0) begin
				ref_cnt <= ref_reload;
				ref_pending <= 1'b1; // Wins over the clear above.
			end else begin
				ref_cnt <= ref_cnt - 1'b1;
			end
		end
	end

endmodule

/* design/hpdmc_timing_pkg.sv */
// Runtime timing codes cover CL2 and CL3 only, and the timer counters are 4 bits wide.
`include "hpdmc_config.svh"

package hpdmc_timing_pkg;

	typedef logic cas_t; // 0 selects CL2 and 1 selects CL3.
	typedef logic [1:0] twr_t; // Extra write-recovery cycles.

	// Countdown used by the safety, direction and gap timers.
	typedef logic [3:0] tcnt_t;

	// Refresh interval counter.
	typedef logic [$clog2(`HPDMC_REFRESH_CYCLES+1)-1:0] refcnt_t;

	// Command sequencer states.
	typedef enum logic [2:0] {
		st_idle = 3'd0, // Waiting for a request or a refresh.
		st_precharge_wait = 3'd1, // Counting tRP.
		st_activate_wait = 3'd2, // Counting tRCD.
		st_issue = 3'd3, // Read or write, then wait for ack.
		st_refresh_wait = 3'd4 // Counting tRFC.
	} mgmt_state_t;

endpackage

/* hpdmc.f */
+incdir+design
design/hpdmc_cmd_pkg.sv
design/hpdmc_timing_pkg.sv
design/hpdmc_banktimer.sv
design/hpdmc_datactl.sv
design/hpdmc_arbiter.sv
design/hpdmc_mgmt.sv
design/hpdmc_ctl.sv
verif/hpdmc_assert.sv
verif/hpdmc_tb.sv

/* verif/hpdmc_assert.sv */
// Bound into hpdmc_ctl; all checks except the post-reset NOP check are off while sdram_rst is high.

module hpdmc_assert (
	input logic sys_clk,
	input logic sdram_rst,
	input hpdmc_cmd_pkg::sdram_cmd_t sdram_cmd,
	input logic read,
	input logic write,
	input logic dq_oe
);
	timeunit 1ns;
	timeprecision 1ps;

	import hpdmc_cmd_pkg::*;

	// DQ drive opens only the cycle after a write on the pins.
	oe_after_write: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		$rose(dq_oe) |-> ($past(sdram_cmd) == cmd_write))
		else $error("dq_oe rose without a write command one cycle before");

	// Bus is idle once reset has been seen.
	nop_after_reset: assert property (@(posedge sys_clk)
		sdram_rst |=> (sdram_cmd == cmd_nop))
		else $error("sdram_cmd was not NOP in the cycle after reset");

	// Only one column strobe per cycle.
	single_strobe: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		!(read && write))
		else $error("read and write strobes high in the same cycle");

endmodule

bind hpdmc_ctl hpdmc_assert i_assert (
	.sys_clk(sys_clk),
	.sdram_rst(sdram_rst),
	.sdram_cmd(sdram_cmd),
	.read(read),
	.write(write),
	.dq_oe(dq_oe)
);

/* verif/hpdmc_tb.sv */
// Command timing and routing only; there is no SDRAM array model, so data is never checked.
`include "hpdmc_config.svh"

module hpdmc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import hpdmc_cmd_pkg::*;
	import hpdmc_timing_pkg::*;

	localparam int clk_period = 4;
	localparam int reqs_per_client = 60; // Per client, per half.
	localparam int ref_limit = `HPDMC_REFRESH_CYCLES + 40;
	localparam int watchdog_cycles = 4 * reqs_per_client * 60 + 2 * ref_limit;

	logic sys_clk = 1'b0;
	logic sdram_rst;
	cas_t tim_cas;
	twr_t tim_wr;
	logic req [2];
	logic we [2];
	mem_addr_t addr [2];
	logic ack_0;
	logic ack_1;
	sdram_cmd_t sdram_cmd;
	bank_t sdram_ba;
	row_t sdram_a;
	logic dq_oe;
	logic dq_oe_r;

	logic [31:0] lfsr;
	int cyc; // Negedge count.
	int mismatches;
	int failures;
	row_t hot_rows [4]; // Few rows so hits are common.

	logic outstanding [2]; // Request waiting for its ack.
	logic just_acked [2];
	int issued_cnt [2];
	int acked_cnt [2];
	bank_t req_bank [2];
	row_t req_row [2];
	col_t req_col [2];
	logic expect_valid; // Round robin owes the next ack.
	int expect_client;

	logic bank_open [`HPDMC_NBANKS];
	row_t bank_row [`HPDMC_NBANKS];
	int act_time [`HPDMC_NBANKS];
	int pre_time [`HPDMC_NBANKS];
	logic rd_valid;
	logic wr_valid;
	int rd_time; // Last read command.
	int wr_time; // Last write command.
	logic pre_all_seen;
	int pre_all_time;
	int ref_time; // Last refresh, or reset.
	logic ref_late;
	int ref_count;

	logic col_pending; // Column command waiting for ack.
	int col_time;
	logic col_we;
	bank_t col_bank;
	col_t col_col;
	row_t col_row;

	always #(clk_period / 2) sys_clk = ~sys_clk;

	hpdmc_ctl i_dut (
		.sys_clk(sys_clk),
		.sdram_rst(sdram_rst),
		.tim_cas(tim_cas),
		.tim_wr(tim_wr),
		.req_0(req[0]),
		.we_0(we[0]),
		.addr_0(addr[0]),
		.ack_0(ack_0),
		.req_1(req[1]),
		.we_1(we[1]),
		.addr_1(addr[1]),
		.ack_1(ack_1),
		.sdram_cmd(sdram_cmd),
		.sdram_ba(sdram_ba),
		.sdram_a(sdram_a),
		.dq_oe(dq_oe),
		.dq_oe_r(dq_oe_r)
	);

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // One step per bit.
			val = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic int ack_latency(logic is_write);
		return is_write ? 2 : (tim_cas ? 5 : 4);
	endfunction

	task automatic report_mismatch(input string msg);
		mismatches++;
		$display("mismatch at %0d ns: %s", $time, msg);
	endtask

	task automatic report_failure(input string msg);
		failures++;
		$display("error at %0d ns: %s", $time, msg);
	endtask

	task automatic print_counts();
		$display("done: %0d mismatches, %0d other errors, client acks %0d/%0d and %0d/%0d",
			mismatches, failures, acked_cnt[0], issued_cnt[0], acked_cnt[1], issued_cnt[1]);
	endtask

	task automatic reset_model();
		for (int b = 0; b < `HPDMC_NBANKS; b++) begin
			bank_open[b] = 1'b0;
			act_time[b] = -100;
			pre_time[b] = -100;
		end
		rd_valid = 1'b0;
		wr_valid = 1'b0;
		pre_all_seen = 1'b0;
		ref_time = cyc;
		ref_late = 1'b0;
		ref_count = 0;
		col_pending = 1'b0;
		expect_valid = 1'b0;
		outstanding[0] = 1'b0;
		outstanding[1] = 1'b0;
	endtask

	task automatic new_request(input int c);
		logic [31:0] r;
		logic [31:0] sel;
		draw(1, r);
		we[c] = r[0];
		draw(2, r);
		req_bank[c] = bank_t'(r);
		draw(3, sel);
		if (sel[2:0] != 3'd7) begin
			req_row[c] = hot_rows[sel[1:0]];
		end else begin
			draw(13, r);
			req_row[c] = row_t'(r); // Rare cold row.
		end
		draw(9, r);
		req_col[c] = col_t'(r);
		addr[c] = {req_bank[c], req_row[c], req_col[c]};
		req[c] = 1'b1;
		outstanding[c] = 1'b1;
		issued_cnt[c]++;
	endtask

	task automatic check_ack(input int c);
		if (!outstanding[c]) begin
			report_failure($sformatf("client %0d acknowledged without a request", c));
		end else begin
			if (!col_pending) begin
				report_failure($sformatf("client %0d ack without a read or write command", c));
			end else begin
				if (col_we != we[c])
					report_mismatch($sformatf("client %0d command we=%b, request we=%b",
						c, col_we, we[c]));
				if (cyc - col_time != ack_latency(col_we))
					report_mismatch($sformatf("ack %0d cycles after command, expected %0d",
						cyc - col_time, ack_latency(col_we)));
				if (col_bank != req_bank[c])
					report_mismatch($sformatf("bank %0d, expected %0d", col_bank, req_bank[c]));
				if (col_row != req_row[c])
					report_mismatch($sformatf("open row %h, expected %h", col_row, req_row[c]));
				if (col_col != req_col[c])
					report_mismatch($sformatf("column %h, expected %h", col_col, req_col[c]));
				col_pending = 1'b0;
			end
			if (expect_valid && expect_client != c)
				report_mismatch($sformatf("ack to client %0d, round robin expects %0d",
					c, expect_client));
			expect_valid = outstanding[1 - c]; // Other client waits, so it goes next.
			expect_client = 1 - c;
			outstanding[c] = 1'b0;
			req[c] = 1'b0;
			just_acked[c] = 1'b1;
			acked_cnt[c]++;
		end
	endtask

	task automatic check_column();
		logic is_wr;
		is_wr = (sdram_cmd == cmd_write);
		if (rd_valid && cyc - rd_time < (is_wr ? (tim_cas ? 8 : 9) : 7))
			report_mismatch($sformatf("%0d cycles from read to %s",
				cyc - rd_time, is_wr ? "write" : "read"));
		if (wr_valid && cyc - wr_time < (is_wr ? 7 : (tim_cas ? 6 : 7)))
			report_mismatch($sformatf("%0d cycles from write to %s",
				cyc - wr_time, is_wr ? "write" : "read"));
		if (!bank_open[sdram_ba])
			report_failure($sformatf("read or write to bank %0d with no open row", sdram_ba));
		else if (cyc - act_time[sdram_ba] < `HPDMC_TRCD)
			report_mismatch($sformatf("%0d cycles from activate to column command",
				cyc - act_time[sdram_ba]));
		if (col_pending)
			report_failure("second read or write before the first was acknowledged");
		col_pending = 1'b1;
		col_time = cyc;
		col_we = is_wr;
		col_bank = sdram_ba;
		col_col = sdram_a[`HPDMC_COL_W-1:0];
		col_row = bank_row[sdram_ba];
		if (is_wr) begin
			wr_valid = 1'b1;
			wr_time = cyc;
		end else begin
			rd_valid = 1'b1;
			rd_time = cyc;
		end
	endtask

	task automatic check_command();
		case (sdram_cmd)
			cmd_activate: begin
				if (bank_open[sdram_ba])
					report_failure($sformatf("activate to bank %0d without a precharge", sdram_ba));
				if (cyc - pre_time[sdram_ba] < `HPDMC_TRP)
					report_mismatch($sformatf("activate %0d cycles after precharge",
						cyc - pre_time[sdram_ba]));
				bank_open[sdram_ba] = 1'b1;
				bank_row[sdram_ba] = sdram_a;
				act_time[sdram_ba] = cyc;
			end
			cmd_precharge: begin
				if (sdram_a[10]) begin
					for (int b = 0; b < `HPDMC_NBANKS; b++) begin
						bank_open[b] = 1'b0;
						pre_time[b] = cyc;
					end
					pre_all_seen = 1'b1;
					pre_all_time = cyc;
				end else begin
					bank_open[sdram_ba] = 1'b0;
					pre_time[sdram_ba] = cyc;
				end
			end
			cmd_refresh: begin
				if (!pre_all_seen)
					report_failure("refresh without a precharge of all banks before it");
				else if (cyc - pre_all_time < `HPDMC_TRP)
					report_mismatch($sformatf("refresh %0d cycles after precharge all",
						cyc - pre_all_time));
				for (int b = 0; b < `HPDMC_NBANKS; b++) begin
					if (bank_open[b])
						report_failure($sformatf("refresh while bank %0d has an open row", b));
				end
				pre_all_seen = 1'b0;
				ref_time = cyc;
				ref_late = 1'b0;
				ref_count++;
			end
			cmd_read, cmd_write: check_column();
			default: ;
		endcase
	endtask

	task automatic check_cycle();
		logic [1:0] acks;
		logic exp_oe;
		logic exp_oe_r;
		acks = {ack_1, ack_0};
		if (sdram_rst) begin
			reset_model();
		end else begin
			// Window is 1..10 cycles after the last write and the early view leads it by one.
			exp_oe = wr_valid && (cyc - wr_time >= 1) && (cyc - wr_time <= 10);
			exp_oe_r = (sdram_cmd == cmd_write) ||
				(wr_valid && (cyc - wr_time >= 1) && (cyc - wr_time <= 9));
			if (dq_oe !== exp_oe)
				report_mismatch($sformatf("dq_oe is %b, expected %b", dq_oe, exp_oe));
			if (dq_oe_r !== exp_oe_r)
				report_mismatch($sformatf("dq_oe_r is %b, expected %b", dq_oe_r, exp_oe_r));
			if (acks == 2'b11)
				report_failure("both clients acknowledged in the same cycle");
			else if (acks != 2'b00)
				check_ack(acks[1] ? 1 : 0);
			if (col_pending && cyc - col_time > ack_latency(col_we)) begin
				report_failure("no ack arrived for a read or write command");
				col_pending = 1'b0;
			end
			check_command();
			if (cyc - ref_time > ref_limit && !ref_late) begin
				report_failure("refresh interval exceeded the allowed spacing");
				ref_late = 1'b1;
			end
		end
	endtask

	task automatic drive_clients(input int quota);
		logic [31:0] r;
		for (int c = 0; c < 2; c++) begin
			if (just_acked[c]) begin
				just_acked[c] = 1'b0; // Idle for the ack cycle.
			end else if (!outstanding[c] && issued_cnt[c] < quota) begin
				draw(2, r);
				if (r[1:0] != 2'd0)
					new_request(c);
			end
		end
	endtask

	task automatic step(input int quota);
		@(negedge sys_clk);
		cyc++;
		check_cycle(); // Outputs first, then new inputs.
		drive_clients(quota);
	endtask

	task automatic run_half(input int half);
		int quota;
		quota = reqs_per_client * (half + 1);
		sdram_rst = 1'b1;
		tim_cas = cas_t'(half);
		req[0] = 1'b0;
		req[1] = 1'b0;
		repeat (2) step(0);
		sdram_rst = 1'b0;
		while (issued_cnt[0] < quota || issued_cnt[1] < quota || outstanding[0] || outstanding[1])
			step(quota);
		repeat (20) step(quota);
		for (int c = 0; c < 2; c++) begin
			if (acked_cnt[c] != issued_cnt[c])
				report_failure($sformatf("client %0d got %0d acks for %0d requests",
					c, acked_cnt[c], issued_cnt[c]));
		end
		if (ref_count == 0)
			report_failure($sformatf("no refresh command in half %0d", half));
	endtask

	initial begin
		lfsr = 32'h5999;
		sdram_rst = 1'b1;
		tim_cas = 1'b0;
		tim_wr = 2'd1;
		for (int c = 0; c < 2; c++) begin
			req[c] = 1'b0;
			we[c] = 1'b0;
			addr[c] = '0;
			just_acked[c] = 1'b0;
		end
		hot_rows[0] = 13'h0010;
		hot_rows[1] = 13'h0011;
		hot_rows[2] = 13'h0a5c;
		hot_rows[3] = 13'h1fff;
		reset_model();
		run_half(0); // CL2.
		run_half(1); // CL3.
		print_counts();
		if (mismatches == 0 && failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Ends a stuck run.
	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired after %0d cycles with requests still open", watchdog_cycles);
		print_counts();
		$display("=== FAIL ===");
		$finish;
	end

endmodule
